// File: Makefile
TOOL       := verilator
TOP        := tb_top
FILELIST   := files.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Regression passed$$" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/atop_mem_top.sv
// Top level with the ATOP filter in front of the write and read engines and the array
`timescale 1ns/1ps
`default_nettype none

module atop_mem_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  axi_sub_pkg::axi_req_t  slv_req_i,
  output axi_sub_pkg::axi_resp_t slv_resp_o
);
  import axi_sub_pkg::*;

  // Filtered bus toward memory
  axi_req_t  mem_req;
  axi_resp_t mem_resp;
  // Array ports
  mem_wr_t   mem_wr;
  idx_t      rd_idx;
  data_t     rd_data;

  axi_atop_filter u_filter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .slv_req_i  (slv_req_i),
    .slv_resp_o (slv_resp_o),
    .mst_req_o  (mem_req),
    .mst_resp_i (mem_resp)
  );

  // AW, W and B side
  mem_write_ctrl u_write (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .aw_i       (mem_req.aw),
    .aw_valid_i (mem_req.aw_valid),
    .aw_ready_o (mem_resp.aw_ready),
    .w_i        (mem_req.w),
    .w_valid_i  (mem_req.w_valid),
    .w_ready_o  (mem_resp.w_ready),
    .b_o        (mem_resp.b),
    .b_valid_o  (mem_resp.b_valid),
    .b_ready_i  (mem_req.b_ready),
    .wr_o       (mem_wr)
  );

  // AR and R side
  mem_read_ctrl u_read (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ar_i       (mem_req.ar),
    .ar_valid_i (mem_req.ar_valid),
    .ar_ready_o (mem_resp.ar_ready),
    .r_o        (mem_resp.r),
    .r_valid_o  (mem_resp.r_valid),
    .r_ready_i  (mem_req.r_ready),
    .rd_idx_o   (rd_idx),
    .rd_data_i  (rd_data)
  );

  mem_array u_array (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wr_i      (mem_wr),
    .rd_idx_i  (rd_idx),
    .rd_data_o (rd_data)
  );

endmodule

`default_nettype wire

// File: design/axi_atop_filter.sv
// AXI ATOP filter that absorbs atomic bursts and injects SLVERR B and R responses
`timescale 1ns/1ps
`default_nettype none

module axi_atop_filter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Upstream port
  input  axi_sub_pkg::axi_req_t  slv_req_i,
  output axi_sub_pkg::axi_resp_t slv_resp_o,
  // Downstream port toward memory
  output axi_sub_pkg::axi_req_t  mst_req_o,
  input  axi_sub_pkg::axi_resp_t mst_resp_i
);
  import axi_sub_pkg::*;

  typedef logic [$clog2(MaxWriteTxns+1)-1:0] cnt_t;

  typedef enum logic [2:0] {
    WFeedthrough,
    WBlockAw,
    WAbsorbW,
    WInjectB,
    WWaitR
  } w_state_t;

  typedef enum logic {
    RFeedthrough,
    RInjectR
  } r_state_t;

  w_state_t w_state_d, w_state_q;
  r_state_t r_state_d, r_state_q;
  // Downstream bursts with AW accepted but W not complete
  cnt_t     w_cnt_d, w_cnt_q;
  // Id of the atomic burst being answered
  id_t      id_d, id_q;
  // Injected R beat number
  len_t     r_beat_d, r_beat_q;

  // One-entry R command register
  logic cmd_valid_q;
  len_t cmd_len_q;
  logic cmd_push, cmd_pop;

  logic aw_is_atop, aw_needs_r;

  // Only the top two atop bits tell the kind
  assign aw_is_atop = slv_req_i.aw.atop[5:4] != AtopNone;
  assign aw_needs_r = slv_req_i.aw.atop[5:4] != AtopAtomicStore;

  always_comb begin
    // Write side defaults block AW and W and pass B through
    mst_req_o.aw        = slv_req_i.aw;
    mst_req_o.aw.atop   = '0;
    mst_req_o.aw_valid  = 1'b0;
    mst_req_o.w         = slv_req_i.w;
    mst_req_o.w_valid   = 1'b0;
    mst_req_o.b_ready   = slv_req_i.b_ready;
    slv_resp_o.aw_ready = 1'b0;
    slv_resp_o.w_ready  = 1'b0;
    slv_resp_o.b        = mst_resp_i.b;
    slv_resp_o.b_valid  = mst_resp_i.b_valid;
    id_d                = id_q;
    cmd_push            = 1'b0;
    w_state_d           = w_state_q;

    unique case (w_state_q)
      WFeedthrough: begin
        // AW passes while below the outstanding limit
        if (w_cnt_q < cnt_t'(MaxWriteTxns)) begin
          mst_req_o.aw_valid  = slv_req_i.aw_valid;
          slv_resp_o.aw_ready = mst_resp_i.aw_ready;
        end
        // W passes only behind an accepted AW
        if (w_cnt_q != '0) begin
          mst_req_o.w_valid  = slv_req_i.w_valid;
          slv_resp_o.w_ready = mst_resp_i.w_ready;
        end
        // Atomic AW is taken here and never reaches memory
        if (slv_req_i.aw_valid && aw_is_atop) begin
          mst_req_o.aw_valid  = 1'b0;
          slv_resp_o.aw_ready = 1'b1;
          id_d                = slv_req_i.aw.id;
          // Atomic store gets a B only
          if (aw_needs_r) begin
            cmd_push = 1'b1;
          end
          if (w_cnt_q != '0) begin
            // Earlier W bursts drain first
            w_state_d = WBlockAw;
          end else begin
            mst_req_o.w_valid  = 1'b0;
            slv_resp_o.w_ready = 1'b1;
            if (slv_req_i.w_valid && slv_req_i.w.last) begin
              w_state_d = WInjectB;
            end else begin
              w_state_d = WAbsorbW;
            end
          end
        end
      end

      WBlockAw: begin
        if (w_cnt_q != '0) begin
          // Let pending downstream bursts finish
          mst_req_o.w_valid  = slv_req_i.w_valid;
          slv_resp_o.w_ready = mst_resp_i.w_ready;
        end else begin
          // Next W burst belongs to the atomic AW
          slv_resp_o.w_ready = 1'b1;
          if (slv_req_i.w_valid && slv_req_i.w.last) begin
            w_state_d = WInjectB;
          end else begin
            w_state_d = WAbsorbW;
          end
        end
      end

      WAbsorbW: begin
        // Drop the atomic W beats
        slv_resp_o.w_ready = 1'b1;
        if (slv_req_i.w_valid && slv_req_i.w.last) begin
          w_state_d = WInjectB;
        end
      end

      WInjectB: begin
        // Hold off memory B and answer with SLVERR
        mst_req_o.b_ready  = 1'b0;
        slv_resp_o.b.id    = id_q;
        slv_resp_o.b.resp  = RespSlvErr;
        slv_resp_o.b_valid = 1'b1;
        if (slv_req_i.b_ready) begin
          // Error beats may still be owed
          if (cmd_valid_q) begin
            w_state_d = WWaitR;
          end else begin
            w_state_d = WFeedthrough;
          end
        end
      end

      WWaitR: begin
        // R injection still running
        if (!cmd_valid_q) begin
          w_state_d = WFeedthrough;
        end
      end

      default: w_state_d = WFeedthrough;
    endcase

    // Read side defaults pass AR and R through
    mst_req_o.ar        = slv_req_i.ar;
    mst_req_o.ar_valid  = slv_req_i.ar_valid;
    mst_req_o.r_ready   = slv_req_i.r_ready;
    slv_resp_o.ar_ready = mst_resp_i.ar_ready;
    slv_resp_o.r        = mst_resp_i.r;
    slv_resp_o.r_valid  = mst_resp_i.r_valid;
    cmd_pop             = 1'b0;
    r_beat_d            = r_beat_q;
    r_state_d           = r_state_q;

    unique case (r_state_q)
      RFeedthrough: begin
        // Injection starts the cycle after the atomic AW
        if (cmd_push) begin
          r_beat_d  = '0;
          r_state_d = RInjectR;
        end
      end

      RInjectR: begin
        // Memory R waits while error beats go out
        mst_req_o.r_ready  = 1'b0;
        slv_resp_o.r.id    = id_q;
        slv_resp_o.r.data  = '0;
        slv_resp_o.r.resp  = RespSlvErr;
        slv_resp_o.r.last  = r_beat_q == cmd_len_q;
        slv_resp_o.r_valid = 1'b1;
        if (slv_req_i.r_ready) begin
          if (slv_resp_o.r.last) begin
            cmd_pop   = 1'b1;
            r_state_d = RFeedthrough;
          end else begin
            r_beat_d = r_beat_q + 1'b1;
          end
        end
      end

      default: r_state_d = RFeedthrough;
    endcase

    // Count AW handshakes up and last W handshakes down
    w_cnt_d = w_cnt_q;
    if (mst_req_o.aw_valid && mst_resp_i.aw_ready) begin
      w_cnt_d = w_cnt_d + 1'b1;
    end
    if (mst_req_o.w_valid && mst_resp_i.w_ready && mst_req_o.w.last) begin
      w_cnt_d = w_cnt_d - 1'b1;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      w_state_q   <= WFeedthrough;
      r_state_q   <= RFeedthrough;
      w_cnt_q     <= '0;
      r_beat_q    <= '0;
      cmd_valid_q <= 1'b0;
    end else begin
      w_state_q <= w_state_d;
      r_state_q <= r_state_d;
      w_cnt_q   <= w_cnt_d;
      r_beat_q  <= r_beat_d;
      if (cmd_push) begin
        cmd_valid_q <= 1'b1;
      end else if (cmd_pop) begin
        cmd_valid_q <= 1'b0;
      end
    end
  end

  // Atomic id and len
  always_ff @(posedge clk_i) begin
    id_q <= id_d;
    if (cmd_push) begin
      cmd_len_q <= slv_req_i.aw.len;
    end
  end

  // Memory never sees an atomic AW
  a_no_atop_down: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_req_o.aw_valid |-> slv_req_i.aw.atop[5:4] == AtopNone)
    else $error("atomic AW forwarded to the memory port");

  // Injected B holds until taken
  a_inj_b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (w_state_q == WInjectB && !slv_req_i.b_ready) |=>
      (slv_resp_o.b_valid && slv_resp_o.b.resp == RespSlvErr && $stable(slv_resp_o.b)))
    else $error("injected B dropped before b_ready");

endmodule

`default_nettype wire

// File: design/axi_sub_pkg.sv
// AXI widths, channel and bundle structs, atop and response codes, memory sizing
`default_nettype none

package axi_sub_pkg;

  // Fixed AXI widths
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 8;
  localparam int unsigned DataWidth = 32;

  // Outstanding downstream write bursts allowed by the filter
  localparam int unsigned MaxWriteTxns = 2;

  // Memory depth in words
  localparam int unsigned MemWords     = 64;
  localparam int unsigned WordIdxWidth = $clog2(MemWords);
  // Byte offset bits inside one data word
  localparam int unsigned ByteOffWidth = $clog2(DataWidth / 8);

  // Field types
  typedef logic [IdWidth-1:0]       id_t;
  typedef logic [AddrWidth-1:0]     addr_t;
  typedef logic [DataWidth-1:0]     data_t;
  typedef logic [DataWidth/8-1:0]   strb_t;
  typedef logic [7:0]               len_t;
  typedef logic [5:0]               atop_t;
  typedef logic [1:0]               burst_t;
  typedef logic [1:0]               resp_t;
  typedef logic [WordIdxWidth-1:0]  idx_t;

  // Codes for atop[5:4]
  localparam logic [1:0] AtopNone        = 2'b00;
  localparam logic [1:0] AtopAtomicStore = 2'b01;

  // Response codes
  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespSlvErr = 2'b10;

  // Write address channel
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    burst_t burst;
    atop_t  atop;
  } aw_chan_t;

  // Write data channel
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  // Write response channel
  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  // Read address channel
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    burst_t burst;
  } ar_chan_t;

  // Read data channel
  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } r_chan_t;

  // Master to slave bundle
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Slave to master bundle
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axi_resp_t;

  // Array write port
  typedef struct packed {
    logic  we;
    idx_t  idx;
    data_t data;
  } mem_wr_t;

endpackage

`default_nettype wire

// File: design/mem_array.sv
// Word array with one clocked write port and one combinational read port
`timescale 1ns/1ps
`default_nettype none

module mem_array (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  axi_sub_pkg::mem_wr_t wr_i,
  input  axi_sub_pkg::idx_t    rd_idx_i,
  output axi_sub_pkg::data_t   rd_data_o
);
  import axi_sub_pkg::*;

  data_t mem_q [MemWords];

  // Cleared on reset so reads of unwritten words give zero
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < MemWords; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_i.we) begin
      mem_q[wr_i.idx] <= wr_i.data;
    end
  end

  // Same-cycle write is seen on the next cycle
  assign rd_data_o = mem_q[rd_idx_i];

endmodule

`default_nettype wire

// File: design/mem_read_ctrl.sv
// Memory read engine returning R beats from the array for each AR burst
`timescale 1ns/1ps
`default_nettype none

module mem_read_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // AR channel
  input  axi_sub_pkg::ar_chan_t ar_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  // R channel
  output axi_sub_pkg::r_chan_t  r_o,
  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  // Array read port
  output axi_sub_pkg::idx_t     rd_idx_o,
  input  axi_sub_pkg::data_t    rd_data_i
);
  import axi_sub_pkg::*;

  typedef enum logic {
    RdIdle,
    RdData
  } rd_state_t;

  rd_state_t state_d, state_q;
  id_t       id_q;
  idx_t      idx_q;
  // Beats left after the current one
  len_t      beats_q;
  logic      ar_hs, r_hs;

  assign ar_ready_o = state_q == RdIdle;
  assign r_valid_o  = state_q == RdData;

  assign ar_hs = ar_valid_i && ar_ready_o;
  assign r_hs  = r_valid_o && r_ready_i;

  // Beat data comes straight from the array
  assign rd_idx_o = idx_q;
  assign r_o.id   = id_q;
  assign r_o.data = rd_data_i;
  assign r_o.resp = RespOkay;
  assign r_o.last = beats_q == '0;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      RdIdle: if (ar_hs) state_d = RdData;
      RdData: if (r_hs && r_o.last) state_d = RdIdle;
      default: state_d = RdIdle;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RdIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // Burst context; one word per accepted beat
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      id_q    <= ar_i.id;
      idx_q   <= ar_i.addr[ByteOffWidth +: WordIdxWidth];
      beats_q <= ar_i.len;
    end else if (r_hs && !r_o.last) begin
      idx_q   <= idx_q + 1'b1;
      beats_q <= beats_q - 1'b1;
    end
  end

  // Stalled beat keeps valid and payload
  a_r_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (r_valid_o && !r_ready_i) |=> (r_valid_o && $stable(r_o)))
    else $error("R beat changed before r_ready");

endmodule

`default_nettype wire

// File: design/mem_write_ctrl.sv
// Memory write engine taking AW and W bursts into the array and returning B
`timescale 1ns/1ps
`default_nettype none

module mem_write_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // AW channel
  input  axi_sub_pkg::aw_chan_t aw_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  // W channel
  input  axi_sub_pkg::w_chan_t  w_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  // B channel
  output axi_sub_pkg::b_chan_t  b_o,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  // Array write port
  output axi_sub_pkg::mem_wr_t  wr_o
);
  import axi_sub_pkg::*;

  typedef enum logic [1:0] {
    WrIdle,
    WrData,
    WrResp
  } wr_state_t;

  wr_state_t state_d, state_q;
  id_t       id_q;
  // Word that takes the next W beat
  idx_t      idx_q;
  logic      aw_hs, w_hs, b_hs;

  assign aw_ready_o = state_q == WrIdle;
  assign w_ready_o  = state_q == WrData;
  assign b_valid_o  = state_q == WrResp;

  assign aw_hs = aw_valid_i && aw_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;
  assign b_hs  = b_valid_o && b_ready_i;

  // Every accepted beat lands in the array that cycle
  assign wr_o.we   = w_hs;
  assign wr_o.idx  = idx_q;
  assign wr_o.data = w_i.data;

  assign b_o.id   = id_q;
  assign b_o.resp = RespOkay;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      WrIdle: if (aw_hs) state_d = WrData;
      WrData: if (w_hs && w_i.last) state_d = WrResp;
      WrResp: if (b_hs) state_d = WrIdle;
      default: state_d = WrIdle;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= WrIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // Burst id and running word index
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      id_q  <= aw_i.id;
      idx_q <= aw_i.addr[ByteOffWidth +: WordIdxWidth];
    end else if (w_hs) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  // Filter forwards W only behind an AW this engine holds open
  a_w_in_burst: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_i |-> state_q == WrData)
    else $error("W beat presented with no open burst");

endmodule

`default_nettype wire

// File: files.f
design/axi_sub_pkg.sv
design/mem_array.sv
design/mem_write_ctrl.sv
design/mem_read_ctrl.sv
design/axi_atop_filter.sv
design/atop_mem_top.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: verif/tb_checker.sv
// Monitor of the DUT slave port with a word memory model and response scoreboard
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  axi_sub_pkg::axi_req_t  slv_req_i,
  input  axi_sub_pkg::axi_resp_t slv_resp_i,
  output int                     err_cnt_o,
  output int                     chk_cnt_o,
  output int                     pend_o
);
  import axi_sub_pkg::*;

  data_t   model [MemWords];
  b_chan_t exp_b [$];
  r_chan_t exp_r [$];
  // Open write burst, dropped if atomic
  idx_t    wr_idx;
  logic    wr_drop;
  // Stalled beats from the last edge
  logic    b_stall;
  logic    r_stall;
  b_chan_t b_prev;
  r_chan_t r_prev;

  task automatic report_error(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    err_cnt_o++;
  endtask

  task automatic clear_state();
    int k;
    for (k = 0; k < MemWords; k++) model[k] = '0;
    exp_b.delete();
    exp_r.delete();
    wr_idx    = '0;
    wr_drop   = 1'b0;
    b_stall   = 1'b0;
    r_stall   = 1'b0;
    err_cnt_o = 0;
    chk_cnt_o = 0;
  endtask

  // A stalled beat must come back unchanged
  task automatic check_hold();
    if (b_stall && (!slv_resp_i.b_valid || slv_resp_i.b != b_prev))
      report_error("B valid or payload changed before b_ready");
    if (r_stall && (!slv_resp_i.r_valid || slv_resp_i.r != r_prev))
      report_error("R valid or payload changed before r_ready");
    b_stall = slv_resp_i.b_valid && !slv_req_i.b_ready;
    r_stall = slv_resp_i.r_valid && !slv_req_i.r_ready;
    b_prev  = slv_resp_i.b;
    r_prev  = slv_resp_i.r;
  endtask

  task automatic watch_requests();
    b_chan_t b;
    r_chan_t r;
    int      i;
    if (slv_req_i.aw_valid && slv_resp_i.aw_ready) begin
      wr_idx  = slv_req_i.aw.addr[7:2];
      wr_drop = slv_req_i.aw.atop[5:4] != AtopNone;
      b.id    = slv_req_i.aw.id;
      b.resp  = wr_drop ? RespSlvErr : RespOkay;
      exp_b.push_back(b);
      // Atomics other than store also owe len+1 error beats
      if (wr_drop && slv_req_i.aw.atop[5:4] != AtopAtomicStore) begin
        for (i = 0; i <= int'(slv_req_i.aw.len); i++) begin
          r.id   = slv_req_i.aw.id;
          r.data = '0;
          r.resp = RespSlvErr;
          r.last = i == int'(slv_req_i.aw.len);
          exp_r.push_back(r);
        end
      end
    end
    if (slv_req_i.w_valid && slv_resp_i.w_ready) begin
      if (!wr_drop) model[wr_idx] = slv_req_i.w.data;
      wr_idx = wr_idx + idx_t'(1);
    end
    // Read data snapshot of the model at AR time
    if (slv_req_i.ar_valid && slv_resp_i.ar_ready) begin
      for (i = 0; i <= int'(slv_req_i.ar.len); i++) begin
        r.id   = slv_req_i.ar.id;
        r.data = model[idx_t'(int'(slv_req_i.ar.addr[7:2]) + i)];
        r.resp = RespOkay;
        r.last = i == int'(slv_req_i.ar.len);
        exp_r.push_back(r);
      end
    end
  endtask

  task automatic check_responses();
    b_chan_t eb;
    r_chan_t er;
    if (slv_resp_i.b_valid && slv_req_i.b_ready) begin
      chk_cnt_o++;
      if (exp_b.size() == 0) begin
        report_error("B response arrived with no write outstanding");
      end else begin
        eb = exp_b.pop_front();
        if (slv_resp_i.b != eb)
          report_error($sformatf("B got id %h resp %0d, expected id %h resp %0d",
                       slv_resp_i.b.id, slv_resp_i.b.resp, eb.id, eb.resp));
      end
    end
    if (slv_resp_i.r_valid && slv_req_i.r_ready) begin
      chk_cnt_o++;
      if (exp_r.size() == 0) begin
        report_error("R beat arrived with no read outstanding");
      end else begin
        er = exp_r.pop_front();
        if (slv_resp_i.r != er)
          report_error($sformatf("R got id %h data %h resp %0d last %0b, expected %h %h %0d %0b",
                       slv_resp_i.r.id, slv_resp_i.r.data, slv_resp_i.r.resp,
                       slv_resp_i.r.last, er.id, er.data, er.resp, er.last));
      end
    end
  endtask

  // Sampled at the edge, before any update of this cycle
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      clear_state();
    end else begin
      check_hold();
      watch_requests();
      check_responses();
    end
    pend_o = exp_b.size() + exp_r.size();
  end

endmodule

`default_nettype wire

// File: verif/tb_top.sv
// Testbench top with clock, reset, random AXI transaction generator, DUT and checker
`timescale 1ns/1ps
`default_nettype none

module tb_top;
  import axi_sub_pkg::*;

  localparam int NumTxns = 300;
  // Cycles allowed for any single wait
  localparam int Timeout = 1000;

  logic        clk_i;
  logic        rst_ni;
  axi_req_t    slv_req;
  axi_resp_t   slv_resp;
  // Generator side of the request, readies merged in below
  axi_req_t    drv;
  logic        b_rdy = 1'b0;
  logic        r_rdy = 1'b0;
  int          seed = 32'ha662;
  int          rdy_seed = 32'ha662;
  logic [31:0] rdy_rnd;
  // Response handshakes seen so far
  int          b_cnt;
  int          r_cnt;
  int          err_cnt;
  int          chk_cnt;
  int          pend;
  logic        timed_out;

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always_comb begin
    slv_req         = drv;
    slv_req.b_ready = b_rdy;
    slv_req.r_ready = r_rdy;
  end

  atop_mem_top DUT (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .slv_req_i  (slv_req),
    .slv_resp_o (slv_resp)
  );

  tb_checker u_checker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .slv_req_i  (slv_req),
    .slv_resp_i (slv_resp),
    .err_cnt_o  (err_cnt),
    .chk_cnt_o  (chk_cnt),
    .pend_o     (pend)
  );

  // Random back-pressure on B and R, ready about three cycles in four
  always @(posedge clk_i) begin
    if (rst_ni) begin
      rdy_rnd = $random(rdy_seed);
      b_rdy <= rdy_rnd[1:0] != 2'b00;
      r_rdy <= rdy_rnd[3:2] != 2'b00;
    end
  end

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      b_cnt <= 0;
      r_cnt <= 0;
    end else begin
      if (slv_resp.b_valid && slv_req.b_ready) b_cnt <= b_cnt + 1;
      if (slv_resp.r_valid && slv_req.r_ready) r_cnt <= r_cnt + 1;
    end
  end

  // Word aligned start that keeps a 4 beat burst inside the array
  function automatic addr_t pick_addr(input logic [31:0] rnd);
    logic [31:0] word;
    word = rnd % 32'd61;
    return {word[5:0], 2'b00};
  endfunction

  task automatic send_aw(input aw_chan_t aw);
    int t;
    drv.aw       <= aw;
    drv.aw_valid <= 1'b1;
    t = 0;
    do begin
      @(posedge clk_i);
      t++;
    end while (!slv_resp.aw_ready && t < Timeout);
    drv.aw_valid <= 1'b0;
    if (!slv_resp.aw_ready) begin
      $display("Timeout: AW with id %h was never accepted", aw.id);
      timed_out = 1'b1;
    end
  endtask

  task automatic send_w_burst(input len_t len);
    logic [31:0] rnd;
    int          beat;
    int          t;
    for (beat = 0; beat <= int'(len) && !timed_out; beat++) begin
      rnd = $random(seed);
      drv.w.data  <= rnd;
      drv.w.strb  <= '1;
      drv.w.last  <= beat == int'(len);
      drv.w_valid <= 1'b1;
      t = 0;
      do begin
        @(posedge clk_i);
        t++;
      end while (!slv_resp.w_ready && t < Timeout);
      if (!slv_resp.w_ready) begin
        $display("Timeout: W beat %0d was never accepted", beat);
        timed_out = 1'b1;
      end
    end
    drv.w_valid <= 1'b0;
  endtask

  task automatic send_ar(input ar_chan_t ar);
    int t;
    drv.ar       <= ar;
    drv.ar_valid <= 1'b1;
    t = 0;
    do begin
      @(posedge clk_i);
      t++;
    end while (!slv_resp.ar_ready && t < Timeout);
    drv.ar_valid <= 1'b0;
    if (!slv_resp.ar_ready) begin
      $display("Timeout: AR with id %h was never accepted", ar.id);
      timed_out = 1'b1;
    end
  endtask

  // Wait until the handshake counters reach their targets
  task automatic wait_resps(input int b_target, input int r_target);
    int t;
    t = 0;
    while ((b_cnt < b_target || r_cnt < r_target) && t < Timeout) begin
      @(posedge clk_i);
      t++;
    end
    if (b_cnt < b_target || r_cnt < r_target) begin
      $display("Timeout: got %0d of %0d B and %0d of %0d R responses",
               b_cnt, b_target, r_cnt, r_target);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_write();
    aw_chan_t    aw;
    logic [31:0] rnd;
    int          b_target;
    int          r_target;
    rnd      = $random(seed);
    aw.id    = rnd[3:0];
    aw.len   = {6'b0, rnd[5:4]};
    aw.burst = 2'b01;
    // Half plain writes, a quarter atomic stores, a quarter loads, swaps or compares
    case (rnd[7:6])
      2'd2:    aw.atop = {AtopAtomicStore, rnd[11:8]};
      2'd3:    aw.atop = {1'b1, rnd[12], rnd[11:8]};
      default: aw.atop = '0;
    endcase
    aw.addr  = pick_addr($random(seed));
    b_target = b_cnt + 1;
    r_target = r_cnt;
    if (aw.atop[5:4] != AtopNone && aw.atop[5:4] != AtopAtomicStore) begin
      r_target = r_cnt + int'(aw.len) + 1;
    end
    send_aw(aw);
    if (!timed_out) send_w_burst(aw.len);
    if (!timed_out) wait_resps(b_target, r_target);
  endtask

  task automatic run_read();
    ar_chan_t    ar;
    logic [31:0] rnd;
    rnd      = $random(seed);
    ar.id    = rnd[3:0];
    ar.len   = {6'b0, rnd[5:4]};
    ar.burst = 2'b01;
    ar.addr  = pick_addr($random(seed));
    send_ar(ar);
    if (!timed_out) wait_resps(b_cnt, r_cnt + int'(ar.len) + 1);
  endtask

  initial begin
    int          n;
    logic [31:0] rnd;
    drv       = '0;
    timed_out = 1'b0;
    rst_ni    = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    // One transaction at a time, each fully answered before the next
    for (n = 0; n < NumTxns && !timed_out; n++) begin
      rnd = $random(seed);
      if (rnd[0]) run_write();
      else run_read();
    end
    repeat (2) @(posedge clk_i);
    $display("Transactions: %0d, checks: %0d, errors: %0d, pending: %0d, timeout: %0b",
             n, chk_cnt, err_cnt, pend, timed_out);
    if (!timed_out && err_cnt == 0 && pend == 0 && chk_cnt > 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
